// ==== common/ifm_pkg.sv ====
package ifm_pkg;

	// ==============================
	// feature map sizes
	// ==============================

	localparam int DATA_WIDTH = 32; // one pixel word of the feature map.
	localparam int IFM_SIZE = 14; // the map is square.
	localparam int IFM_DEPTH = IFM_SIZE * IFM_SIZE; // words held by one bank.
	localparam int ADDR_WIDTH = 8; // smallest width that reaches every word of a bank.

	// ==============================
	// word and address types
	// ==============================

	typedef logic [DATA_WIDTH-1:0] pixel_t;
	typedef logic [ADDR_WIDTH-1:0] ifm_addr_t;
	typedef logic bank_sel_t; // 0 means the previous layer owns bank 0.

	// ==============================
	// port bundles
	// ==============================

	// requests from the layer that produces the map.
	typedef struct packed {
		logic      wr_en;
		ifm_addr_t wr_addr;
		pixel_t    wr_data;
		logic      rd_en; // readback of the bank being filled.
		ifm_addr_t rd_addr;
	} prev_req_t;

	// requests from the layer that consumes the map.
	typedef struct packed {
		logic      rd_a_en;
		ifm_addr_t rd_a_addr;
		logic      rd_b_en;
		ifm_addr_t rd_b_addr;
	} next_req_t;

	typedef struct packed {
		pixel_t data_a;
		pixel_t data_b;
	} next_data_t;

	// what one bank sees after steering.
	typedef struct packed {
		logic      wr_en; // port A write.
		ifm_addr_t addr_a;
		pixel_t    wr_data;
		logic      rd_a_en; // port A read.
		logic      rd_b_en; // port B read.
		ifm_addr_t addr_b;
	} bank_req_t;

endpackage

// ==== hw/ifm_buffer_top.sv ====
module ifm_buffer_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                swap,
	input  ifm_pkg::prev_req_t  prev_req,
	input  ifm_pkg::next_req_t  next_req,
	output ifm_pkg::pixel_t     prev_rd_data,
	output ifm_pkg::next_data_t next_data,
	output ifm_pkg::bank_sel_t  bank_sel
);

	// ==============================
	// ping-pong storage
	// ==============================

	// bank_sel leaves the block so each layer knows which map it holds.
	ifm_pingpong_array array_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.swap         (swap),
		.prev_req     (prev_req),
		.next_req     (next_req),
		.prev_rd_data (prev_rd_data),
		.next_data    (next_data),
		.bank_sel     (bank_sel)
	);

endmodule

// ==== hw/ifm_mem_bank.sv ====
module ifm_mem_bank (
	input  logic               clk,
	input  logic               rst_n,
	input  ifm_pkg::bank_req_t req,
	output ifm_pkg::pixel_t    rd_a,
	output ifm_pkg::pixel_t    rd_b
);

	// ==============================
	// storage and address guard
	// ==============================

	ifm_pkg::pixel_t mem [ifm_pkg::IFM_DEPTH];

	logic addr_a_ok;
	logic addr_b_ok;

	// addresses past the last pixel fall outside the map.
	assign addr_a_ok = req.addr_a < ifm_pkg::ifm_addr_t'(ifm_pkg::IFM_DEPTH);
	assign addr_b_ok = req.addr_b < ifm_pkg::ifm_addr_t'(ifm_pkg::IFM_DEPTH);

	// ==============================
	// port A
	// ==============================

	always_ff @(posedge clk)
	begin
		if (req.wr_en && addr_a_ok)
		begin
			mem[req.addr_a] <= req.wr_data; // stored at the same edge the strobe is sampled.
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_a <= '0;
		end
		else if (req.rd_a_en)
		begin
			if (addr_a_ok)
			begin
				rd_a <= mem[req.addr_a];
			end
			else
			begin
				rd_a <= '0; // reads outside the map return zero.
			end
		end
	end

	// ==============================
	// port B
	// ==============================

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_b <= '0;
		end
		else if (req.rd_b_en)
		begin
			if (addr_b_ok)
			begin
				rd_b <= mem[req.addr_b];
			end
			else
			begin
				rd_b <= '0;
			end
		end
	end // without a strobe the last word stays on the port.

endmodule

// ==== mem_array/ifm_pingpong_array.sv ====
module ifm_pingpong_array (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                swap,
	input  ifm_pkg::prev_req_t  prev_req,
	input  ifm_pkg::next_req_t  next_req,
	output ifm_pkg::pixel_t     prev_rd_data,
	output ifm_pkg::next_data_t next_data,
	output ifm_pkg::bank_sel_t  bank_sel
);

	// ==============================
	// request mapping
	// ==============================

	// The previous layer writes on port A and reads back on port B of the
	// bank it owns. Port A never reads for it.
	function automatic ifm_pkg::bank_req_t prev_side(input ifm_pkg::prev_req_t p);
		ifm_pkg::bank_req_t r;
		r = '0;
		r.wr_en = p.wr_en;
		r.addr_a = p.wr_addr;
		r.wr_data = p.wr_data;
		r.rd_b_en = p.rd_en;
		r.addr_b = p.rd_addr;
		return r;
	endfunction

	// the next layer only reads, so its bank sees no write strobe.
	function automatic ifm_pkg::bank_req_t next_side(input ifm_pkg::next_req_t n);
		ifm_pkg::bank_req_t r;
		r = '0;
		r.rd_a_en = n.rd_a_en;
		r.addr_a = n.rd_a_addr;
		r.rd_b_en = n.rd_b_en;
		r.addr_b = n.rd_b_addr;
		return r;
	endfunction

	ifm_pkg::bank_req_t prev_bank_req;
	ifm_pkg::bank_req_t next_bank_req;
	ifm_pkg::bank_req_t bank0_req;
	ifm_pkg::bank_req_t bank1_req;

	ifm_pkg::pixel_t bank0_rd_a;
	ifm_pkg::pixel_t bank0_rd_b;
	ifm_pkg::pixel_t bank1_rd_a;
	ifm_pkg::pixel_t bank1_rd_b;

	// ==============================
	// bank select
	// ==============================

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			bank_sel <= 1'b0; // previous layer starts in bank 0.
		end
		else if (swap)
		begin
			bank_sel <= ~bank_sel; // one pulse hands the filled map over.
		end
	end

	// ==============================
	// steering into the banks
	// ==============================

	assign prev_bank_req = prev_side(prev_req);
	assign next_bank_req = next_side(next_req);

	// Each bank takes exactly one side's request. The side that does not
	// own it contributes nothing, so no fields are merged.
	always_comb
	begin
		case (bank_sel)
			1'b0:
			begin
				bank0_req = prev_bank_req;
				bank1_req = next_bank_req;
			end
			default:
			begin
				bank0_req = next_bank_req;
				bank1_req = prev_bank_req;
			end
		endcase
	end

	ifm_mem_bank bank0_i (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (bank0_req),
		.rd_a  (bank0_rd_a),
		.rd_b  (bank0_rd_b)
	);

	ifm_mem_bank bank1_i (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (bank1_req),
		.rd_a  (bank1_rd_a),
		.rd_b  (bank1_rd_b)
	);

	// ==============================
	// read data back to the layers
	// ==============================

	always_comb
	begin
		case (bank_sel)
			1'b0:
			begin
				prev_rd_data = bank0_rd_b; // readback always comes from port B.
				next_data.data_a = bank1_rd_a;
				next_data.data_b = bank1_rd_b;
			end
			default:
			begin
				prev_rd_data = bank1_rd_b;
				next_data.data_a = bank0_rd_a;
				next_data.data_b = bank0_rd_b;
			end
		endcase
	end // follows the current select, so data read before a swap changes sides with it.

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the IFM buffer testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_ifm_buffer
LOG_FILE=sim.log

verilator --binary --timing -j 0 \
	--top-module tb_ifm_buffer \
	--Mdir "$BUILD_DIR" -o "$SIM_BIN" \
	-f verilog.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

# the run counts as passed only if the testbench printed its pass line.
if grep -q "^TEST PASSED$" "$LOG_FILE"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $LOG_FILE"
	exit 1
fi

// ==== test/ifm_buffer_golden.txt ====
# name swap wr_en wr_addr wr_data rd_en rd_addr a_en a_addr b_en b_addr chk_prev exp_prev chk_next exp_a exp_b chk_sel exp_sel
# all fields hex; the checks on a line see the reads requested on the line before it
reset 0 0 00 00000000 0 00 0 00 0 00 1 00000000 1 00000000 00000000 1 0
fill_b0 0 1 00 0a000000 0 00 0 00 0 00 0 00000000 0 00000000 00000000 1 0
fill_b0 0 1 01 0a000001 0 00 0 00 0 00 0 00000000 0 00000000 00000000 1 0
fill_b0 0 1 02 0a000002 0 00 0 00 0 00 0 00000000 0 00000000 00000000 1 0
fill_b0 0 1 03 0a000003 0 00 0 00 0 00 0 00000000 0 00000000 00000000 1 0
fill_b0 0 1 04 0a000004 0 00 0 00 0 00 0 00000000 0 00000000 00000000 1 0
fill_b0 0 1 05 0a000005 0 00 0 00 0 00 0 00000000 0 00000000 00000000 1 0
fill_b0 0 1 06 0a000006 0 00 0 00 0 00 0 00000000 0 00000000 00000000 1 0
fill_b0 0 1 07 0a000007 0 00 0 00 0 00 0 00000000 0 00000000 00000000 1 0
fill_b0 0 1 0d 0a00000d 0 00 0 00 0 00 0 00000000 0 00000000 00000000 1 0
fill_b0 0 1 0e 0a00000e 0 00 0 00 0 00 0 00000000 0 00000000 00000000 1 0
fill_b0 0 1 61 0a000061 0 00 0 00 0 00 0 00000000 0 00000000 00000000 1 0
fill_b0 0 1 c3 0a0000c3 0 00 0 00 0 00 0 00000000 0 00000000 00000000 1 0
readback_b0 0 0 00 00000000 1 00 0 00 0 00 1 00000000 0 00000000 00000000 1 0
readback_b0 0 0 00 00000000 1 01 0 00 0 00 1 0a000000 0 00000000 00000000 1 0
readback_b0 0 0 00 00000000 1 02 0 00 0 00 1 0a000001 0 00000000 00000000 1 0
readback_b0 0 0 00 00000000 1 03 0 00 0 00 1 0a000002 0 00000000 00000000 1 0
readback_b0 0 0 00 00000000 1 04 0 00 0 00 1 0a000003 0 00000000 00000000 1 0
readback_b0 0 0 00 00000000 1 05 0 00 0 00 1 0a000004 0 00000000 00000000 1 0
readback_b0 0 0 00 00000000 1 06 0 00 0 00 1 0a000005 0 00000000 00000000 1 0
readback_b0 0 0 00 00000000 1 07 0 00 0 00 1 0a000006 0 00000000 00000000 1 0
readback_b0 0 0 00 00000000 1 0d 0 00 0 00 1 0a000007 0 00000000 00000000 1 0
readback_b0 0 0 00 00000000 1 0e 0 00 0 00 1 0a00000d 0 00000000 00000000 1 0
readback_b0 0 0 00 00000000 1 61 0 00 0 00 1 0a00000e 0 00000000 00000000 1 0
readback_b0 0 0 00 00000000 1 c3 0 00 0 00 1 0a000061 0 00000000 00000000 1 0
readback_b0 0 0 00 00000000 0 00 0 00 0 00 1 0a0000c3 0 00000000 00000000 1 0
swap1 1 0 00 00000000 0 00 0 00 0 00 1 0a0000c3 0 00000000 00000000 1 0
handover 0 1 00 c0de0000 0 00 1 00 1 c3 1 00000000 1 00000000 0a0000c3 1 1
handover 0 1 01 c0de0001 0 00 1 01 1 61 0 00000000 1 0a000000 0a0000c3 1 1
handover 0 1 02 c0de0002 0 00 1 02 1 0e 0 00000000 1 0a000001 0a000061 1 1
handover 0 1 03 c0de0003 0 00 1 03 1 0d 0 00000000 1 0a000002 0a00000e 1 1
handover 0 1 04 c0de0004 0 00 1 04 1 07 0 00000000 1 0a000003 0a00000d 1 1
handover 0 1 05 c0de0005 0 00 1 05 1 06 0 00000000 1 0a000004 0a000007 1 1
handover 0 1 06 c0de0006 0 00 1 06 1 05 0 00000000 1 0a000005 0a000006 1 1
handover 0 1 07 c0de0007 0 00 1 07 1 04 0 00000000 1 0a000006 0a000005 1 1
handover 0 1 0d c0de000d 0 00 1 0d 1 03 0 00000000 1 0a000007 0a000004 1 1
handover 0 1 0e c0de000e 0 00 1 0e 1 02 0 00000000 1 0a00000d 0a000003 1 1
handover 0 1 61 c0de0061 0 00 1 61 1 01 0 00000000 1 0a00000e 0a000002 1 1
handover 0 1 c3 c0de00c3 0 00 1 c3 1 00 0 00000000 1 0a000061 0a000001 1 1
readback_b1 0 0 00 00000000 1 00 0 00 0 00 1 00000000 1 0a0000c3 0a000000 1 1
readback_b1 0 0 00 00000000 1 61 0 00 0 00 1 c0de0000 1 0a0000c3 0a000000 1 1
readback_b1 0 0 00 00000000 0 00 0 00 0 00 1 c0de0061 1 0a0000c3 0a000000 1 1
hold 0 0 00 00000000 0 00 0 00 0 00 1 c0de0061 1 0a0000c3 0a000000 1 1
hold 0 0 00 00000000 0 00 0 00 0 00 1 c0de0061 1 0a0000c3 0a000000 1 1
hold 0 0 00 00000000 0 00 0 00 0 00 1 c0de0061 1 0a0000c3 0a000000 1 1
swap2 1 0 00 00000000 0 00 0 00 0 00 1 c0de0061 1 0a0000c3 0a000000 1 1
swap2_roles 0 0 00 00000000 1 05 1 00 1 c3 1 0a000000 1 00000000 c0de0061 1 0
swap2_roles 0 1 10 0f000010 1 0e 1 0d 1 61 1 0a000005 1 c0de0000 c0de00c3 1 0
swap2_roles 0 0 00 00000000 1 10 1 01 1 07 1 0a00000e 1 c0de000d c0de0061 1 0
swap2_roles 0 0 00 00000000 1 c3 1 02 1 06 1 0f000010 1 c0de0001 c0de0007 1 0
swap2_roles 0 0 00 00000000 0 00 0 00 0 00 1 0a0000c3 1 c0de0002 c0de0006 1 0
guard_wr 0 1 c8 deadbeef 0 00 0 00 0 00 1 0a0000c3 1 c0de0002 c0de0006 1 0
guard_chk 0 0 00 00000000 1 04 0 00 0 00 1 0a0000c3 1 c0de0002 c0de0006 1 0
guard_chk 0 0 00 00000000 1 c3 0 00 0 00 1 0a000004 1 c0de0002 c0de0006 1 0
guard_rd 0 0 00 00000000 1 c8 1 c8 1 ff 1 0a0000c3 1 c0de0002 c0de0006 1 0
guard_rd 0 0 00 00000000 1 00 0 00 0 00 1 00000000 1 00000000 00000000 1 0
guard_rd 0 0 00 00000000 0 00 1 c3 1 00 1 0a000000 1 00000000 00000000 1 0
hold_a 0 0 00 00000000 0 00 1 0e 0 00 1 0a000000 1 c0de00c3 c0de0000 1 0
hold_b 0 0 00 00000000 0 00 0 00 1 01 1 0a000000 1 c0de000e c0de0000 1 0
hold_b 0 0 00 00000000 0 00 0 00 0 00 1 0a000000 1 c0de000e c0de0001 1 0
swap3 1 0 00 00000000 0 00 0 00 0 00 1 0a000000 1 c0de000e c0de0001 1 0
swap3_roles 0 0 00 00000000 0 00 1 10 1 04 1 c0de0001 1 0a0000c3 0a000000 1 1
swap3_roles 0 0 00 00000000 0 00 0 00 0 00 1 c0de0001 1 0f000010 0a000004 1 1

// ==== test/tb_ifm_buffer.sv ====
module tb_ifm_buffer;

	// ==============================
	// timing and stimulus source
	// ==============================

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10; // inputs change this long after the rising edge.
	localparam int CHECK_LEAD = 10; // outputs are sampled this long before the next edge.
	localparam int RESET_CYCLES = 10;
	localparam int MARGIN_CYCLES = 20;
	localparam int GOLDEN_FIELDS = 18;
	localparam string GOLDEN_FILE = "test/ifm_buffer_golden.txt";

	// one line of the golden file, name excluded.
	typedef struct packed {
		logic                swap;
		ifm_pkg::prev_req_t  prev_req;
		ifm_pkg::next_req_t  next_req;
		logic                chk_prev;
		ifm_pkg::pixel_t     exp_prev;
		logic                chk_next;
		ifm_pkg::next_data_t exp_next;
		logic                chk_sel;
		ifm_pkg::bank_sel_t  exp_sel;
	} golden_vec_t;

	golden_vec_t vectors[$];
	string       names[$];
	bit          loaded = 1'b0;

	logic                clk;
	logic                rst_n;
	logic                swap;
	ifm_pkg::prev_req_t  prev_req;
	ifm_pkg::next_req_t  next_req;
	ifm_pkg::pixel_t     prev_rd_data;
	ifm_pkg::next_data_t next_data;
	ifm_pkg::bank_sel_t  bank_sel;

	ifm_buffer_top ifm_buffer_top_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.swap         (swap),
		.prev_req     (prev_req),
		.next_req     (next_req),
		.prev_rd_data (prev_rd_data),
		.next_data    (next_data),
		.bank_sel     (bank_sel)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// ==============================
	// failure and compare tasks
	// ==============================

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare_pixel(input string test_name, input ifm_pkg::pixel_t expected,
		input ifm_pkg::pixel_t actual);
		if (actual !== expected)
		begin
			stop_with_failure($sformatf("** Error [%s] prev_rd_data expected %h actual %h",
				test_name, expected, actual));
		end
	endtask

	task automatic compare_next_data(input string test_name,
		input ifm_pkg::next_data_t expected, input ifm_pkg::next_data_t actual);
		if (actual !== expected)
		begin
			stop_with_failure($sformatf(
				"** Error [%s] next_data expected a=%h b=%h actual a=%h b=%h", test_name,
				expected.data_a, expected.data_b, actual.data_a, actual.data_b));
		end
	endtask

	task automatic compare_bank_sel(input string test_name, input ifm_pkg::bank_sel_t expected,
		input ifm_pkg::bank_sel_t actual);
		if (actual !== expected)
		begin
			stop_with_failure($sformatf("** Error [%s] bank_sel expected %b actual %b",
				test_name, expected, actual));
		end
	endtask

	// ==============================
	// golden file, drive and check
	// ==============================

	task automatic load_golden();
		int          fd;
		int          count;
		string       line;
		string       name;
		golden_vec_t v;
		logic [31:0] swap_val;
		logic [31:0] wr_en_val, wr_addr_val, wr_data_val, rd_en_val, rd_addr_val;
		logic [31:0] a_en_val, a_addr_val, b_en_val, b_addr_val;
		logic [31:0] chk_prev_val, prev_val, chk_next_val, a_val, b_val;
		logic [31:0] chk_sel_val, sel_val;
		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0)
		begin
			stop_with_failure({"cannot open the golden file ", GOLDEN_FILE});
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				if (line.len() >= 2 && line.getc(0) != "#") // blank and comment lines are skipped.
				begin
					v = '0;
					count = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						name, swap_val, wr_en_val, wr_addr_val, wr_data_val, rd_en_val,
						rd_addr_val, a_en_val, a_addr_val, b_en_val, b_addr_val,
						chk_prev_val, prev_val, chk_next_val, a_val, b_val,
						chk_sel_val, sel_val);
					if (count != GOLDEN_FIELDS)
					begin
						stop_with_failure({"malformed line in the golden file: ", line});
					end
					else
					begin
						v.swap = swap_val[0];
						v.prev_req.wr_en = wr_en_val[0];
						v.prev_req.wr_addr = ifm_pkg::ifm_addr_t'(wr_addr_val);
						v.prev_req.wr_data = wr_data_val;
						v.prev_req.rd_en = rd_en_val[0];
						v.prev_req.rd_addr = ifm_pkg::ifm_addr_t'(rd_addr_val);
						v.next_req.rd_a_en = a_en_val[0];
						v.next_req.rd_a_addr = ifm_pkg::ifm_addr_t'(a_addr_val);
						v.next_req.rd_b_en = b_en_val[0];
						v.next_req.rd_b_addr = ifm_pkg::ifm_addr_t'(b_addr_val);
						v.chk_prev = chk_prev_val[0];
						v.exp_prev = prev_val;
						v.chk_next = chk_next_val[0];
						v.exp_next.data_a = a_val;
						v.exp_next.data_b = b_val;
						v.chk_sel = chk_sel_val[0];
						v.exp_sel = sel_val[0];
						names.push_back(name);
						vectors.push_back(v);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic apply_vector(input golden_vec_t v);
		swap = v.swap;
		prev_req = v.prev_req;
		next_req = v.next_req;
	endtask

	task automatic check_vector(input string test_name, input golden_vec_t v);
		if (v.chk_prev)
		begin
			compare_pixel(test_name, v.exp_prev, prev_rd_data);
		end
		if (v.chk_next)
		begin
			compare_next_data(test_name, v.exp_next, next_data);
		end
		if (v.chk_sel)
		begin
			compare_bank_sel(test_name, v.exp_sel, bank_sel);
		end
	endtask

	initial
	begin
		swap = 1'b0;
		prev_req = '0;
		next_req = '0;
		rst_n = 1'b0;
		load_golden();
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		for (int i = 0; i < vectors.size(); i++)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
			apply_vector(vectors[i]);
			#(CLK_PERIOD - DRIVE_DELAY - CHECK_LEAD);
			check_vector(names[i], vectors[i]); // sees the reads of the line before.
		end
		$display("TEST PASSED");
		$finish;
	end

	// the limit grows with the number of golden lines.
	initial
	begin
		wait (loaded);
		#((vectors.size() * 2 + MARGIN_CYCLES) * CLK_PERIOD);
		stop_with_failure("watchdog timeout: the golden vectors did not finish in time");
	end

endmodule

// ==== verilog.f ====
common/ifm_pkg.sv
hw/ifm_mem_bank.sv
mem_array/ifm_pingpong_array.sv
hw/ifm_buffer_top.sv
test/tb_ifm_buffer.sv
